//--- verif/basic_organ_input.txt
// Columns, all hex: operation, count, expected value
// Ops 1 up hold, 2 down hold, 3 reset key, 4 mute, 5 probe, 6 enable, 7 check hex, 8 check audio, 9 check trace, 0 end
7 208 30d3     // default count 12499 after one refresh
1 3 0          // up for 3 windows
7 208 31ff     // 12799
2 5 0          // down for 5 windows
7 208 300b     // 12299
1 2 0          // up 2 then down 1 accumulate
2 1 0
7 208 306f     // 12399
3 3 0          // reset key for 3 cycles
7 208 30d3     // back to 12499
4 0 0          // mute off
8 c8 7f        // square wave for 200 cycles
4 1 0          // mute on
8 64 0         // silence for 100 cycles
4 0 0          // mute off again
6 1 0          // scope enable on
5 1 0          // probe on
9 30d50 ffff   // 16 x 12501 cycles, ch_b all ones
6 0 0          // scope enable off
5 0 0          // probe off
9 30d50 ffff   // trace holds for 16 more periods
0 0 0          // end of steps

//--- basic_organ.f
verilog/scope_pkg.sv
verilog/panel_pkg.sv
verilog/tick_divider.sv
verilog/key_conditioner.sv
verilog/sample_rate_control.sv
verilog/tone_generator.sv
verilog/scope_capture.sv
verilog/hex_display.sv
verilog/basic_organ.sv
verif/basic_organ_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator, run, then look for the pass message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f basic_organ.f --top-module basic_organ_tb \
  -o sim_basic_organ > build.log 2>&1 \
  && ./obj_dir/sim_basic_organ > sim.log 2>&1 \
  || { cat build.log; echo "Build or run did not complete"; exit 1; }
cat sim.log
grep -qx "Everything OK" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- verif/basic_organ_tb.sv
`default_nettype none
`timescale 1ns/1ps

module basic_organ_tb;

  import scope_pkg::*;
  import panel_pkg::*;

  // Small periods so the run stays short
  localparam int ms_period      = 20;
  localparam int repeat_windows = 4;
  localparam int refresh_period = 500;
  localparam int window_cycles  = ms_period * repeat_windows;
  localparam int reset_cycles   = 2;
  localparam int max_steps      = 64;

  // Operation codes in the stimulus file
  localparam int op_end      = 0;
  localparam int op_up       = 1;
  localparam int op_down     = 2;
  localparam int op_reset    = 3;
  localparam int op_mute     = 4;
  localparam int op_probe    = 5;
  localparam int op_enable   = 6;
  localparam int op_hex      = 7;
  localparam int op_audio    = 8;
  localparam int op_trace    = 9;

  logic           CLK_50M;
  logic           rst;
  key_bus_t       keys;
  switch_bus_t    switches;
  hex_bus_t       hex;
  audio_sample_t  audio_sample;
  scope_trace_t   scope_trace;

  logic [31:0]    step_mem [0:3*max_steps-1];
  logic [31:0]    lcg_state;
  int             num_steps;
  int             total_cycles;
  int             limit_cycles;
  int             model_offset;
  int             model_count;
  int             op;
  int             count;
  int             expected;
  int             hex_errors;
  int             audio_errors;
  int             trace_errors;
  int             other_errors;

  basic_organ #(
    .tick_cycles    (ms_period),
    .repeat_count   (repeat_windows),
    .refresh_cycles (refresh_period)
  ) basic_organ_inst (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .keys         (keys),
    .switches     (switches),
    .hex          (hex),
    .audio_sample (audio_sample),
    .scope_trace  (scope_trace)
  );

  always #10 CLK_50M = ~CLK_50M;

  // ==============================
  // Reference models
  // ==============================

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    lcg_next = state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Lit segments in active-high gfedcba order
  function automatic segments_t lit_segments(input logic [3:0] nibble);
    case (nibble)
      4'h0:    lit_segments = 7'h3f;
      4'h1:    lit_segments = 7'h06;
      4'h2:    lit_segments = 7'h5b;
      4'h3:    lit_segments = 7'h4f;
      4'h4:    lit_segments = 7'h66;
      4'h5:    lit_segments = 7'h6d;
      4'h6:    lit_segments = 7'h7d;
      4'h7:    lit_segments = 7'h07;
      4'h8:    lit_segments = 7'h7f;
      4'h9:    lit_segments = 7'h6f;
      4'ha:    lit_segments = 7'h77;
      4'hb:    lit_segments = 7'h7c;
      4'hc:    lit_segments = 7'h39;
      4'hd:    lit_segments = 7'h5e;
      4'he:    lit_segments = 7'h79;
      default: lit_segments = 7'h71;
    endcase
  endfunction

  function automatic hex_bus_t expected_digits(input int value);
    hex_bus_t     digits;
    logic [23:0]  wide;
    wide = 24'(value);
    for (int i = 0; i < hex_digits; i++)
      digits[i] = ~lit_segments(wide[4*i +: 4]);
    return digits;
  endfunction

  // Last 16 samples of the tone square wave taken every scope_period cycles
  function automatic logic [15:0] sampled_square(input int phase, input int scope_period);
    logic [15:0]  bits;
    int           pos;
    for (int k = 0; k < 16; k++)
    begin
      pos = (phase + k * scope_period) % (2 * ms_period);
      bits[15-k] = (pos >= ms_period);
    end
    return bits;
  endfunction

  // Worst-case length of one step including the idle gap
  function automatic int step_cycles(input int step_op, input int step_count);
    case (step_op)
      op_up, op_down: step_cycles = (step_count + 3) * window_cycles;
      op_reset:       step_cycles = step_count + 5;
      op_hex, op_audio, op_trace: step_cycles = step_count;
      default:        step_cycles = 5;
    endcase
  endfunction

  // ==============================
  // Compare tasks
  // ==============================

  task automatic check_hex(input string name, input hex_bus_t actual, input hex_bus_t exp_val);
    if (actual !== exp_val)
    begin
      hex_errors++;
      $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, exp_val);
    end
  endtask

  task automatic check_audio(input string name, input audio_sample_t actual,
                             input audio_sample_t exp_val);
    if (actual !== exp_val)
    begin
      audio_errors++;
      $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, exp_val);
    end
  endtask

  task automatic check_trace(input string name, input scope_trace_t actual,
                             input scope_trace_t exp_val);
    if (actual !== exp_val)
    begin
      trace_errors++;
      $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, exp_val);
    end
  endtask

  // ==============================
  // Stimulus tasks
  // ==============================

  // Random idle gap followed by the key held for whole repeat windows
  task automatic hold_key(input int key_op, input int windows);
    int gap;
    lcg_state = lcg_next(lcg_state);
    gap = 1 + int'(lcg_state[31:16] % 3);
    repeat (gap * window_cycles) @(negedge CLK_50M);
    if (key_op == op_up)
      keys.speed_up_n = 1'b0;
    else
      keys.speed_down_n = 1'b0;
    repeat (windows * window_cycles) @(negedge CLK_50M);
    keys = '1;
  endtask

  // Locks onto the first edge and then expects a flip every ms_period cycles
  task automatic observe_audio(input int cycles, input audio_sample_t level);
    audio_sample_t  prev;
    audio_sample_t  predicted;
    int             since_change;
    bit             locked;
    prev = audio_sample;
    since_change = 0;
    locked = 1'b0;
    for (int n = 0; n < cycles; n++)
    begin
      @(negedge CLK_50M);
      if (level == 8'sh00)
        check_audio("audio_sample", audio_sample, 8'sh00);
      else if (locked)
      begin
        since_change++;
        predicted = prev;
        if (since_change == ms_period)
        begin
          predicted = ~prev;
          since_change = 0;
        end
        check_audio("audio_sample", audio_sample, predicted);
        prev = predicted;
      end
      else if (audio_sample !== 8'sh7f && audio_sample !== -8'sh80)
        check_audio("audio_sample", audio_sample, level);
      else if (audio_sample !== prev)
      begin
        locked = 1'b1;
        prev = audio_sample;
      end
    end
    if (level != 8'sh00 && !locked)
    begin
      other_errors++;
      $display("The audio sample never toggled in %0d cycles", cycles);
    end
  endtask

  task automatic check_display(input int step, input int file_count, input int wait_cycles);
    repeat (wait_cycles) @(negedge CLK_50M);
    model_count = default_sample_count + model_offset;
    if (model_count != file_count)
    begin
      other_errors++;
      $display("Step %0d: file expects count %0d but the offset model gives %0d",
               step, file_count, model_count);
    end
    check_hex("hex", hex, expected_digits(model_count));
  endtask

  // Channel A must match the sampled tone at one of its possible phases
  task automatic check_probe_trace(input int wait_cycles, input int ch_b_val);
    scope_trace_t seen;
    scope_trace_t exp_val;
    int           scope_period;
    repeat (wait_cycles) @(negedge CLK_50M);
    seen = scope_trace;
    scope_period = default_sample_count + model_offset;
    exp_val.ch_a = sampled_square(0, scope_period);
    for (int p = 0; p < 2 * ms_period; p++)
      if (sampled_square(p, scope_period) == seen.ch_a)
        exp_val.ch_a = sampled_square(p, scope_period);
    exp_val.ch_b = 16'(ch_b_val);
    check_trace("scope_trace", seen, exp_val);
  endtask

  // ==============================
  // Watchdog
  // ==============================

  initial
  begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge CLK_50M);
    $display("Timeout: the test steps did not finish within %0d cycles", limit_cycles);
    $display("Something failed");
    $finish;
  end

  // ==============================
  // Main sequence
  // ==============================

  initial
  begin
    CLK_50M = 1'b0;
    rst = 1'b1;
    keys = '1;
    switches = '0;
    lcg_state = 32'hb57a4442;
    model_offset = 0;
    hex_errors = 0;
    audio_errors = 0;
    trace_errors = 0;
    other_errors = 0;
    limit_cycles = 0;

    for (int i = 0; i < 3*max_steps; i++)
      step_mem[i] = '0;
    $readmemh("verif/basic_organ_input.txt", step_mem);

    num_steps = 0;
    total_cycles = reset_cycles + 1;
    while (num_steps < max_steps && step_mem[3*num_steps] != op_end)
    begin
      total_cycles += step_cycles(int'(step_mem[3*num_steps]),
                                  int'(step_mem[3*num_steps+1]));
      num_steps++;
    end
    limit_cycles = 2 * total_cycles;

    repeat (reset_cycles) @(posedge CLK_50M);
    @(negedge CLK_50M);
    rst = 1'b0;

    if (num_steps == 0)
    begin
      other_errors++;
      $display("No test steps were read from verif/basic_organ_input.txt");
    end

    for (int s = 0; s < num_steps; s++)
    begin
      op = int'(step_mem[3*s]);
      count = int'(step_mem[3*s+1]);
      expected = int'(step_mem[3*s+2]);
      case (op)
        op_up:
        begin
          hold_key(op_up, count);
          model_offset += count * speed_step;
        end
        op_down:
        begin
          hold_key(op_down, count);
          model_offset -= count * speed_step;
        end
        op_reset:
        begin
          keys.speed_reset_n = 1'b0;
          repeat (count) @(negedge CLK_50M);
          keys = '1;
          model_offset = 0;
          repeat (5) @(negedge CLK_50M);
        end
        op_mute, op_probe, op_enable:
        begin
          if (op == op_mute)
            switches.mute = count[0];
          else if (op == op_probe)
            switches.probe = count[0];
          else
            switches.scope_enable = count[0];
          repeat (5) @(negedge CLK_50M);
        end
        op_hex:   check_display(s, expected, count);
        op_audio: observe_audio(count, audio_sample_t'(expected));
        op_trace: check_probe_trace(count, expected);
        default:
        begin
          other_errors++;
          $display("Step %0d has an unknown operation code %0d", s, op);
        end
      endcase
    end

    $display("Errors: hex %0d, audio %0d, trace %0d, other %0d",
             hex_errors, audio_errors, trace_errors, other_errors);
    if (hex_errors + audio_errors + trace_errors + other_errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/basic_organ.sv
`default_nettype none
`timescale 1ns/1ps

module basic_organ #(
  parameter int tick_cycles    = scope_pkg::ms_tick_cycles,
  parameter int repeat_count   = scope_pkg::repeat_ticks,
  parameter int refresh_cycles = scope_pkg::display_tick_cycles
) (
  input  logic                      CLK_50M,
  input  logic                      rst,
  input  panel_pkg::key_bus_t       keys,
  input  panel_pkg::switch_bus_t    switches,
  output panel_pkg::hex_bus_t       hex,
  output scope_pkg::audio_sample_t  audio_sample,
  output scope_pkg::scope_trace_t   scope_trace
);

  import scope_pkg::*;
  import panel_pkg::*;

  switch_bus_t    sw_meta;
  switch_bus_t    sw_sync;
  logic           ms_tick;
  logic           refresh_tick;
  logic           scope_tick;
  speed_cmd_e     speed_cmd;
  sample_count_t  sample_count;
  logic           tone_bit;

  // ==============================
  // Switch synchronizers
  // ==============================

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      sw_meta <= '0;
      sw_sync <= '0;
    end
    else
    begin
      sw_meta <= switches;
      sw_sync <= sw_meta;
    end
  end

  // ==============================
  // Tick generators
  // ==============================

  tick_divider ms_tick_gen (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .period  (sample_count_t'(tick_cycles)),
    .tick    (ms_tick)
  );

  // Refresh period does not fit in 16 bits
  tick_divider #(
    .period_t (logic [31:0])
  ) refresh_tick_gen (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .period  (32'(refresh_cycles)),
    .tick    (refresh_tick)
  );

  tick_divider scope_tick_gen (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .period  (sample_count),
    .tick    (scope_tick)
  );

  // ==============================
  // Speed control and outputs
  // ==============================

  key_conditioner #(
    .repeat_count (repeat_count)
  ) key_conditioner_inst (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .keys    (keys),
    .ms_tick (ms_tick),
    .cmd     (speed_cmd)
  );

  sample_rate_control sample_rate_control_inst (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .cmd          (speed_cmd),
    .sample_count (sample_count)
  );

  tone_generator tone_generator_inst (
    .CLK_50M  (CLK_50M),
    .rst      (rst),
    .ms_tick  (ms_tick),
    .mute     (sw_sync.mute),
    .tone_bit (tone_bit),
    .sample   (audio_sample)
  );

  // Channel A is the tone, channel B the probe switch
  scope_capture scope_capture_inst (
    .CLK_50M     (CLK_50M),
    .rst         (rst),
    .sample_tick (scope_tick),
    .enable      (sw_sync.scope_enable),
    .ch_a_bit    (tone_bit),
    .ch_b_bit    (sw_sync.probe),
    .trace       (scope_trace)
  );

  hex_display hex_display_inst (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .refresh_tick (refresh_tick),
    .value        (sample_count),
    .hex          (hex)
  );

endmodule

`default_nettype wire

//--- verilog/hex_display.sv
`default_nettype none
`timescale 1ns/1ps

module hex_display (
  input  logic                      CLK_50M,
  input  logic                      rst,
  input  logic                      refresh_tick,
  input  scope_pkg::sample_count_t  value,
  output panel_pkg::hex_bus_t       hex
);

  import panel_pkg::*;

  logic [4*hex_digits-1:0] shown;

  // Nibble to active-low segments, gfedcba
  function automatic segments_t hex_to_seg(input logic [3:0] nibble);
    case (nibble)
      4'h0:    hex_to_seg = 7'h40;
      4'h1:    hex_to_seg = 7'h79;
      4'h2:    hex_to_seg = 7'h24;
      4'h3:    hex_to_seg = 7'h30;
      4'h4:    hex_to_seg = 7'h19;
      4'h5:    hex_to_seg = 7'h12;
      4'h6:    hex_to_seg = 7'h02;
      4'h7:    hex_to_seg = 7'h78;
      4'h8:    hex_to_seg = 7'h00;
      4'h9:    hex_to_seg = 7'h10;
      4'ha:    hex_to_seg = 7'h08;
      4'hb:    hex_to_seg = 7'h03;
      4'hc:    hex_to_seg = 7'h46;
      4'hd:    hex_to_seg = 7'h21;
      4'he:    hex_to_seg = 7'h06;
      default: hex_to_seg = 7'h0e;
    endcase
  endfunction

  // Hold the count between refreshes so the digits stay readable
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      shown <= '0;
    else if (refresh_tick)
      shown <= (4*hex_digits)'(value);
  end

  always_comb
  begin
    for (int i = 0; i < hex_digits; i++)
      hex[i] = hex_to_seg(shown[4*i +: 4]);
  end

endmodule

`default_nettype wire

//--- verilog/scope_capture.sv
`default_nettype none
`timescale 1ns/1ps

module scope_capture (
  input  logic                     CLK_50M,
  input  logic                     rst,
  input  logic                     sample_tick,
  input  logic                     enable,
  input  logic                     ch_a_bit,
  input  logic                     ch_b_bit,
  output scope_pkg::scope_trace_t  trace
);

  logic advance;

  assign advance = sample_tick && enable;

  // Both channels shift together so their samples stay aligned
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      trace <= '0;
    else if (advance)
    begin
      trace.ch_a <= {trace.ch_a[14:0], ch_a_bit};
      trace.ch_b <= {trace.ch_b[14:0], ch_b_bit};
    end
  end

endmodule

`default_nettype wire

//--- verilog/tone_generator.sv
`default_nettype none
`timescale 1ns/1ps

module tone_generator (
  input  logic                      CLK_50M,
  input  logic                      rst,
  input  logic                      ms_tick,
  input  logic                      mute,
  output logic                      tone_bit,
  output scope_pkg::audio_sample_t  sample
);

  import scope_pkg::*;

  // Square wave at half the tick rate
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      tone_bit <= 1'b0;
    else if (ms_tick)
      tone_bit <= ~tone_bit;
  end

  // Full-scale signed levels, +127 or -128
  always_ff @(posedge CLK_50M)
  begin
    if (rst || mute)
      sample <= '0;
    else
      sample <= audio_sample_t'({~tone_bit, {7{tone_bit}}});
  end

endmodule

`default_nettype wire

//--- verilog/sample_rate_control.sv
`default_nettype none
`timescale 1ns/1ps

module sample_rate_control (
  input  logic                      CLK_50M,
  input  logic                      rst,
  input  scope_pkg::speed_cmd_e     cmd,
  output scope_pkg::sample_count_t  sample_count
);

  import scope_pkg::*;

  speed_offset_t offset;

  // Signed offset, wraps freely
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      offset <= '0;
    else
    begin
      case (cmd)
        cmd_up:    offset <= offset + speed_offset_t'(speed_step);
        cmd_down:  offset <= offset - speed_offset_t'(speed_step);
        cmd_reset: offset <= '0;
        default:   offset <= offset;
      endcase
    end
  end

  // 16-bit sum equals default plus the sign-extended offset
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      sample_count <= sample_count_t'(default_sample_count);
    else
      sample_count <= sample_count_t'(default_sample_count) + sample_count_t'(offset);
  end

endmodule

`default_nettype wire

//--- verilog/key_conditioner.sv
`default_nettype none
`timescale 1ns/1ps

module key_conditioner #(
  parameter int repeat_count = scope_pkg::repeat_ticks
) (
  input  logic                   CLK_50M,
  input  logic                   rst,
  input  panel_pkg::key_bus_t    keys,
  input  logic                   ms_tick,
  output scope_pkg::speed_cmd_e  cmd
);

  import scope_pkg::*;
  import panel_pkg::*;

  localparam int cnt_w = $clog2(repeat_count + 1);

  key_bus_t          key_meta;
  key_bus_t          key_sync;
  logic [cnt_w-1:0]  repeat_cnt;
  logic              window_end;
  logic              up_held;
  logic              down_held;
  logic              reset_held;

  // ==============================
  // Key synchronizers
  // ==============================

  // Idle keys read high
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      key_meta <= '1;
      key_sync <= '1;
    end
    else
    begin
      key_meta <= keys;
      key_sync <= key_meta;
    end
  end

  assign up_held    = ~key_sync.speed_up_n;
  assign down_held  = ~key_sync.speed_down_n;
  assign reset_held = ~key_sync.speed_reset_n;

  // ==============================
  // Repeat window
  // ==============================

  assign window_end = ms_tick && (repeat_cnt == cnt_w'(repeat_count - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      repeat_cnt <= '0;
    else if (window_end)
      repeat_cnt <= '0;
    else if (ms_tick)
      repeat_cnt <= repeat_cnt + 1'b1;
  end

  // Reset key wins and acts at once, up and down wait for the window
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      cmd <= cmd_none;
    else if (reset_held)
      cmd <= cmd_reset;
    else if (window_end && up_held)
      cmd <= cmd_up;
    else if (window_end && down_held)
      cmd <= cmd_down;
    else
      cmd <= cmd_none;
  end

endmodule

`default_nettype wire

//--- verilog/tick_divider.sv
`default_nettype none
`timescale 1ns/1ps

module tick_divider #(
  parameter type period_t = scope_pkg::sample_count_t
) (
  input  logic    CLK_50M,
  input  logic    rst,
  input  period_t period,
  output logic    tick
);

  period_t count;

  // Wrap on period-1, or past it if the period just shrank
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      count <= '0;
      tick  <= 1'b0;
    end
    else if (count >= period - period_t'(1))
    begin
      count <= '0;
      tick  <= 1'b1;
    end
    else
    begin
      count <= count + period_t'(1);
      tick  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- verilog/panel_pkg.sv
`default_nettype none

package panel_pkg;

  // Number of seven-segment digits on the board
  localparam int hex_digits = 6;

  // Push keys, low when pressed
  typedef struct packed {
    logic speed_up_n;
    logic speed_down_n;
    logic speed_reset_n;
  } key_bus_t;

  // Slide switches, high when on
  typedef struct packed {
    logic mute;
    logic probe;
    logic scope_enable;
  } switch_bus_t;

  // Active low, segment a in bit 0 through segment g in bit 6
  typedef logic [6:0] segments_t;

  // Digit 0 is the rightmost, least significant nibble
  typedef segments_t [hex_digits-1:0] hex_bus_t;

endpackage

`default_nettype wire

//--- verilog/scope_pkg.sv
`default_nettype none

package scope_pkg;

  // ==============================
  // Timing constants
  // ==============================

  // 1 ms at 50 MHz
  localparam int ms_tick_cycles = 50000;

  // Key repeat interval in ms ticks, ten commands per second
  localparam int repeat_ticks = 100;

  // Display refresh every half second
  localparam int display_tick_cycles = 25_000_000;

  // Offset change per speed command
  localparam int speed_step = 100;

  // Scope period with zero offset
  localparam int default_sample_count = 12499;

  // ==============================
  // Types
  // ==============================

  typedef logic [15:0] sample_count_t;

  typedef logic signed [15:0] speed_offset_t;

  typedef logic signed [7:0] audio_sample_t;

  // One-cycle command from the key conditioner
  typedef enum logic [1:0] {
    cmd_none  = 2'd0,
    cmd_up    = 2'd1,
    cmd_down  = 2'd2,
    cmd_reset = 2'd3
  } speed_cmd_e;

  // Captured scope waveforms, newest sample in bit 0
  typedef struct packed {
    logic [15:0] ch_a;
    logic [15:0] ch_b;
  } scope_trace_t;

endpackage

`default_nettype wire
